/* logic/conv3_settings.svh */
`ifndef CONV3_SETTINGS_SVH
`define CONV3_SETTINGS_SVH

// pixel and weight width
`define CONV3_PIX_W 8
// pixels per image row
`define CONV3_COLS 8
// one row word holds all pixels of a row
`define CONV3_ROW_W 64
// lanes per 3x3 kernel
`define CONV3_TAPS 9
// kernels held in the weight buffer
`define CONV3_KERNELS 8
// 64-bit words per full weight load
`define CONV3_W_WORDS 9
// compute state to o_valid, in cycles
`define CONV3_VALID_LAT 3

`endif

/* logic/conv3_pkg.sv */
`include "conv3_settings.svh"

package conv3_pkg;

	// command code on i_ctrl
	typedef enum logic [1:0] {
		ctrl_end   = 2'd0, // go to finish, sticky
		ctrl_start = 2'd1, // wait -> compute
		ctrl_hold  = 2'd2, // back to wait, clears weight count and stride phase
		ctrl_nop   = 2'd3  // no change
	} ctrl_e;

	// one 72-bit tap word, seen as a 3x3 patch or as nine lanes
	// rows[r][c] and lanes[3r+c] are the same byte
	typedef union packed {
		logic [2:0][2:0][`CONV3_PIX_W-1:0] rows; // row r, column c
		logic [`CONV3_TAPS-1:0][`CONV3_PIX_W-1:0] lanes; // flat lane view
	} tap_word_u;

endpackage

/* logic/row_window.sv */
`timescale 1ns/100ps
`include "conv3_settings.svh"

module row_window (
	input  logic clk,
	input  logic rst,
	input  logic [`CONV3_ROW_W-1:0] i_row_data, // eight pixels, pixel 0 in low byte
	input  logic i_row_valid, // data row strobe
	input  logic i_pad, // zero row strobe
	input  logic i_stride, // 0 stride 1, 1 stride 2
	input  conv3_pkg::ctrl_e i_ctrl,
	output logic [2:0][`CONV3_ROW_W-1:0] o_window // [0] oldest row
);
	import conv3_pkg::*;

	logic [2:0][`CONV3_ROW_W-1:0] rows_q; // [2] newest
	logic [`CONV3_ROW_W-1:0] row_in; // row entering the shift chain
	logic shift; // a row moves in this cycle
	logic phase_q; // stride 2 pair position
	logic take_q; // window copy on the next edge

	assign shift  = i_row_valid | i_pad;
	assign row_in = i_row_valid ? i_row_data : '0; // data beats pad

	// row shift chain
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rows_q <= '0;
		end else if (shift) begin
			rows_q <= {row_in, rows_q[2], rows_q[1]}; // oldest drops out
		end
	end

	// stride 2 only every second shift counts
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			phase_q <= 1'b0;
		end else if (i_ctrl == ctrl_hold) begin
			phase_q <= 1'b0; // restart pairing
		end else if (shift && i_stride) begin
			phase_q <= ~phase_q;
		end
	end

	// decide now, copy one edge later when rows_q holds the new row
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			take_q <= 1'b0;
		end else begin
			take_q <= shift && (!i_stride || phase_q); // 2nd, 4th ... row in stride 2
		end
	end

	// window snapshot for the cubes
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_window <= '0;
		end else if (take_q) begin
			o_window <= rows_q;
		end
	end

	// stride only moves between rows, never with a strobe in flight
	a_stride_stable : assert property (
		@(posedge clk) disable iff (!rst)
		$changed(i_stride) |-> !(i_row_valid || i_pad)
	) else $error("row_window: row or pad strobe during stride change");

endmodule

/* logic/weight_buffer.sv */
`timescale 1ns/100ps
`include "conv3_settings.svh"

module weight_buffer (
	input  logic clk,
	input  logic rst,
	input  logic [`CONV3_ROW_W-1:0] i_w_data, // one weight word
	input  logic i_w_valid, // weight word strobe
	input  conv3_pkg::ctrl_e i_ctrl,
	input  logic [$clog2(`CONV3_KERNELS)-1:0] i_kernel_sel, // kernel 0..7
	output conv3_pkg::tap_word_u o_kernel // registered selected kernel
);
	import conv3_pkg::*;

	localparam int BUF_W  = `CONV3_W_WORDS * `CONV3_ROW_W; // 576 bits
	localparam int KER_W  = `CONV3_TAPS * `CONV3_PIX_W; // 72 bits per kernel
	localparam int CNT_W  = $clog2(`CONV3_W_WORDS + 1); // holds 0..9

	logic [BUF_W-1:0] w_buf; // kernel k at bytes 9k..9k+8
	logic [CNT_W-1:0] w_cnt; // next word slot
	logic w_room; // buffer not yet full

	assign w_room = (w_cnt < `CONV3_W_WORDS);

	// word counter
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			w_cnt <= '0;
		end else if (i_ctrl == ctrl_hold) begin
			w_cnt <= '0; // next load starts at word 0
		end else if (i_w_valid && w_room) begin
			w_cnt <= w_cnt + 1'b1;
		end
	end

	// word k lands at bit 64k
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			w_buf <= '0;
		end else if (i_w_valid && w_room && i_ctrl != ctrl_hold) begin
			w_buf[w_cnt*`CONV3_ROW_W +: `CONV3_ROW_W] <= i_w_data;
		end
	end

	// kernel pick, every cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_kernel <= '0;
		end else begin
			o_kernel.lanes <= w_buf[i_kernel_sel*KER_W +: KER_W]; // lane j = byte 9k+j
		end
	end

	// extra words are dropped so the slot count tops out at nine
	a_cnt_max : assert property (
		@(posedge clk) disable iff (!rst)
		w_cnt <= `CONV3_W_WORDS
	) else $error("weight_buffer: word counter past %0d", `CONV3_W_WORDS);

endmodule

/* logic/tap_cube.sv */
`timescale 1ns/100ps
`include "conv3_settings.svh"

module tap_cube #(
	parameter int POS = 0 // output column 0..7
) (
	input  logic clk,
	input  logic rst,
	input  logic [2:0][`CONV3_ROW_W-1:0] i_window, // [0] oldest row
	input  conv3_pkg::tap_word_u i_kernel,
	input  logic i_stride, // 0 stride 1, 1 stride 2
	output logic [`CONV3_TAPS*`CONV3_PIX_W-1:0] o_product // nine truncated products
);
	import conv3_pkg::*;

	localparam int START1  = POS % `CONV3_COLS; // stride 1 start column
	localparam int START2  = (2 * POS) % `CONV3_COLS; // stride 2 start column
	localparam bit S2_LIVE = (POS < `CONV3_COLS / 2); // upper half idle in stride 2

	tap_word_u patch_s1; // patch for stride 1
	tap_word_u patch_s2; // patch for stride 2
	tap_word_u patch_n; // patch chosen by stride
	tap_word_u patch_q; // stage 1 patch
	tap_word_u kernel_q; // stage 1 kernel
	tap_word_u prod_n; // lane products

	// cut 3x3 out of the window, columns wrap mod 8
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				patch_s1.rows[r][c] =
					i_window[r][((START1 + c) % `CONV3_COLS)*`CONV3_PIX_W +: `CONV3_PIX_W];
				patch_s2.rows[r][c] =
					i_window[r][((START2 + c) % `CONV3_COLS)*`CONV3_PIX_W +: `CONV3_PIX_W];
			end
		end
		if (!i_stride) begin
			patch_n = patch_s1;
		end else if (S2_LIVE) begin
			patch_n = patch_s2;
		end else begin
			patch_n = '0;
		end
	end

	// stage 1 patch and kernel
	always_ff @(posedge clk) begin
		patch_q  <= patch_n;
		kernel_q <= i_kernel;
	end

	// lane multiply, low byte kept
	always_comb begin
		logic [2*`CONV3_PIX_W-1:0] full; // full 16-bit product
		for (int j = 0; j < `CONV3_TAPS; j++) begin
			full = patch_q.lanes[j] * kernel_q.lanes[j];
			prod_n.lanes[j] = full[`CONV3_PIX_W-1:0];
		end
	end

	// stage 2 products
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_product <= '0;
		end else begin
			o_product <= prod_n;
		end
	end

endmodule

/* logic/conv_ctrl_fsm.sv */
`timescale 1ns/100ps
`include "conv3_settings.svh"

module conv_ctrl_fsm (
	input  logic clk,
	input  logic rst,
	input  conv3_pkg::ctrl_e i_ctrl,
	output logic o_valid, // compute state, three cycles late
	output logic o_finish // high in finish
);
	import conv3_pkg::*;

	typedef enum logic [1:0] {
		st_wait    = 2'd0,
		st_compute = 2'd1,
		st_finish  = 2'd2
	} state_e;

	state_e state_q; // current state
	state_e state_n; // next state
	logic [`CONV3_VALID_LAT-1:0] vld_sr; // valid delay line, [0] newest

	always_comb begin
		state_n = state_q;
		case (state_q)
			st_wait: begin
				if (i_ctrl == ctrl_start) state_n = st_compute;
				else if (i_ctrl == ctrl_end) state_n = st_finish;
			end
			st_compute: begin
				if (i_ctrl == ctrl_hold) state_n = st_wait;
				else if (i_ctrl == ctrl_end) state_n = st_finish;
			end
			st_finish: state_n = st_finish; // only reset leaves
			default: state_n = st_wait;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= st_wait;
		end else begin
			state_q <= state_n;
		end
	end

	// three stage delay, matches the window to product latency
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[`CONV3_VALID_LAT-2:0], state_q == st_compute};
		end
	end

	assign o_valid  = vld_sr[`CONV3_VALID_LAT-1];
	assign o_finish = (state_q == st_finish);

	// finish is sticky whatever i_ctrl does
	a_finish_sticky : assert property (
		@(posedge clk) disable iff (!rst)
		state_q == st_finish |=> state_q == st_finish
	) else $error("conv_ctrl_fsm: left finish state");

endmodule

/* logic/conv3_engine.sv */
`timescale 1ns/100ps
`include "conv3_settings.svh"

module conv3_engine (
	input  logic clk,
	input  logic rst,
	input  conv3_pkg::ctrl_e i_ctrl,
	input  logic [`CONV3_ROW_W-1:0] i_row_data,
	input  logic i_row_valid,
	input  logic i_pad,
	input  logic i_stride, // 0 stride 1, 1 stride 2
	input  logic [`CONV3_ROW_W-1:0] i_w_data,
	input  logic i_w_valid,
	input  logic [$clog2(`CONV3_KERNELS)-1:0] i_kernel_sel,
	output logic [`CONV3_COLS*`CONV3_TAPS*`CONV3_PIX_W-1:0] o_products, // position p at 72p
	output logic o_valid,
	output logic o_finish
);
	import conv3_pkg::*;

	localparam int TAP_BITS = `CONV3_TAPS * `CONV3_PIX_W; // one cube slice

	logic [2:0][`CONV3_ROW_W-1:0] window; // shared by all cubes
	tap_word_u kernel; // selected kernel, shared too

	row_window u_row_window (
		.clk         (clk),
		.rst         (rst),
		.i_row_data  (i_row_data),
		.i_row_valid (i_row_valid),
		.i_pad       (i_pad),
		.i_stride    (i_stride),
		.i_ctrl      (i_ctrl),
		.o_window    (window)
	);

	weight_buffer u_weight_buffer (
		.clk          (clk),
		.rst          (rst),
		.i_w_data     (i_w_data),
		.i_w_valid    (i_w_valid),
		.i_ctrl       (i_ctrl),
		.i_kernel_sel (i_kernel_sel),
		.o_kernel     (kernel)
	);

	// one cube per output column
	for (genvar p = 0; p < `CONV3_COLS; p++) begin : g_cube
		tap_cube #(
			.POS (p)
		) u_tap_cube (
			.clk       (clk),
			.rst       (rst),
			.i_window  (window),
			.i_kernel  (kernel),
			.i_stride  (i_stride),
			.o_product (o_products[p*TAP_BITS +: TAP_BITS])
		);
	end

	conv_ctrl_fsm u_conv_ctrl_fsm (
		.clk      (clk),
		.rst      (rst),
		.i_ctrl   (i_ctrl),
		.o_valid  (o_valid),
		.o_finish (o_finish)
	);

endmodule

/* verification/conv3_tb_model.svh */
`ifndef CONV3_TB_MODEL_SVH
`define CONV3_TB_MODEL_SVH

// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// expected products of all eight positions
// win[0] is the oldest row, kernel k sits at bytes 9k..9k+8 of wts
function automatic logic [575:0] ref_products(
	input logic [2:0][63:0] win,
	input logic [575:0] wts,
	input logic [2:0] sel,
	input logic stride
);
	logic [575:0] res;
	logic [7:0] pix;
	logic [7:0] wt;
	logic [15:0] full;
	int start;
	res = '0;
	for (int p = 0; p < 8; p++) begin
		start = stride ? 2 * p : p; // stride 2 steps two columns
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				pix = win[r][8 * ((start + c) % 8) +: 8]; // wraps mod 8
				if (stride && p >= 4) begin
					pix = '0; // upper half idle in stride 2
				end
				wt = wts[72 * sel + 8 * (3 * r + c) +: 8]; // lane 3r+c
				full = pix * wt;
				res[72 * p + 8 * (3 * r + c) +: 8] = full[7:0]; // low byte only
			end
		end
	end
	return res;
endfunction

`endif

/* verification/conv3_engine_tb.sv */
`timescale 1ns/100ps
`include "conv3_settings.svh"

module conv3_engine_tb;
	import conv3_pkg::*;

	`include "conv3_tb_model.svh"

	localparam int PROD_W = `CONV3_COLS * `CONV3_TAPS * `CONV3_PIX_W; // 576
	localparam int RESET_CYCLES = 16;
	localparam int EST_CYCLES = RESET_CYCLES + 40 * 15; // up to 40 checks of about 15 cycles
	localparam int MAX_CYCLES = ((3 * EST_CYCLES + 999) / 1000) * 1000; // thrice, to thousands
	localparam time DRIVE_DLY = 2; // ns after the rising edge

	typedef enum {fsm_wait, fsm_compute, fsm_finish} fsm_e; // model of the ctrl FSM

	logic clk;
	logic rst;
	ctrl_e i_ctrl;
	logic [`CONV3_ROW_W-1:0] i_row_data;
	logic i_row_valid;
	logic i_pad;
	logic i_stride;
	logic [`CONV3_ROW_W-1:0] i_w_data;
	logic i_w_valid;
	logic [2:0] i_kernel_sel;
	logic [PROD_W-1:0] o_products;
	logic o_valid;
	logic o_finish;

	logic [2:0][63:0] m_rows; // model rows, [0] oldest
	logic [2:0][63:0] m_window; // model window
	logic m_phase; // model stride 2 phase
	logic [575:0] m_w; // model weight buffer
	int m_wcnt; // model word counter
	logic [2:0] m_sel;
	logic m_stride;
	fsm_e m_state;

	string chk_name; // handed to the comparing process
	int chk_at; // cycle after which to sample
	logic [PROD_W-1:0] exp_prod;
	logic exp_valid;
	logic exp_finish;
	int req_cnt = 0; // checks requested
	int done_cnt = 0; // checks compared
	int cyc = 0; // rising edges since start
	int err_cnt = 0;
	int chk_cnt = 0;
	string cur_test;
	int test_err0; // errors at test start
	int test_chk0; // checks at test start
	int tests_run = 0;
	int tests_ok = 0;
	logic [31:0] rnd_state = 32'hcc3b;

	conv3_engine uut (
		.clk          (clk),
		.rst          (rst),
		.i_ctrl       (i_ctrl),
		.i_row_data   (i_row_data),
		.i_row_valid  (i_row_valid),
		.i_pad        (i_pad),
		.i_stride     (i_stride),
		.i_w_data     (i_w_data),
		.i_w_valid    (i_w_valid),
		.i_kernel_sel (i_kernel_sel),
		.o_products   (o_products),
		.o_valid      (o_valid),
		.o_finish     (o_finish)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
	end

	initial begin
		wait (cyc >= MAX_CYCLES);
		$display("timeout: run still going after %0d cycles", MAX_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic tick();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic strobes_low();
		i_row_valid = 1'b0;
		i_pad = 1'b0;
		i_w_valid = 1'b0;
	endtask

	// one idle cycle without strobe or command
	task automatic quiet();
		tick();
		strobes_low();
		i_ctrl = ctrl_nop;
	endtask

	task automatic rand64(output logic [63:0] v);
		rnd_state = xorshift32(rnd_state);
		v[31:0] = rnd_state;
		rnd_state = xorshift32(rnd_state);
		v[63:32] = rnd_state;
	endtask

	// model row shift where stride 2 copies only every second row
	task automatic shift_model(input logic [63:0] row);
		m_rows = {row, m_rows[2], m_rows[1]}; // oldest drops out
		if (!m_stride || m_phase) begin
			m_window = m_rows;
		end
		if (m_stride) begin
			m_phase = ~m_phase;
		end
	endtask

	task automatic send_row(input logic [63:0] d, input logic with_pad);
		tick();
		strobes_low();
		i_ctrl = ctrl_nop;
		i_row_data = d;
		i_row_valid = 1'b1;
		i_pad = with_pad; // data row wins anyway
		shift_model(d);
	endtask

	task automatic send_pad();
		tick();
		strobes_low();
		i_ctrl = ctrl_nop;
		i_row_data = '1; // must not leak into the zero row
		i_pad = 1'b1;
		shift_model('0);
	endtask

	task automatic send_weight(input logic [63:0] d);
		tick();
		strobes_low();
		i_ctrl = ctrl_nop;
		i_w_data = d;
		i_w_valid = 1'b1;
		if (m_wcnt < `CONV3_W_WORDS) begin
			m_w[64 * m_wcnt +: 64] = d; // word k at bit 64k
			m_wcnt++;
		end
	endtask

	task automatic set_stride(input logic s);
		tick();
		strobes_low(); // stride never moves with a strobe
		i_stride = s;
		m_stride = s;
	endtask

	task automatic set_kernel(input logic [2:0] k);
		tick();
		strobes_low();
		i_kernel_sel = k;
		m_sel = k;
	endtask

	// one-cycle command driven in cycle at
	task automatic command(input ctrl_e c, output int at);
		tick();
		strobes_low();
		i_ctrl = c;
		at = cyc; // accepted at the next edge
		case (m_state)
			fsm_wait: begin
				if (c == ctrl_start) begin
					m_state = fsm_compute;
				end else if (c == ctrl_end) begin
					m_state = fsm_finish;
				end
			end
			fsm_compute: begin
				if (c == ctrl_hold) begin
					m_state = fsm_wait;
				end else if (c == ctrl_end) begin
					m_state = fsm_finish;
				end
			end
			default: m_state = fsm_finish; // sticky
		endcase
		if (c == ctrl_hold) begin
			m_wcnt = 0;
			m_phase = 1'b0;
		end
		tick();
		i_ctrl = ctrl_nop;
	endtask

	// hand one check to the comparing process and wait for it
	task automatic check_at(input string name, input int at, input logic v, input logic f);
		chk_name = name;
		chk_at = at;
		exp_prod = ref_products(m_window, m_w, m_sel, m_stride);
		exp_valid = v;
		exp_finish = f;
		req_cnt++;
		wait (done_cnt == req_cnt);
	endtask

	// inputs held still for four cycles so the whole pipe settles
	task automatic check_settled(input string name);
		quiet();
		check_at(name, cyc + 4, m_state == fsm_compute, m_state == fsm_finish);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err0 = err_cnt;
		test_chk0 = chk_cnt;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_cnt == test_err0) begin
			tests_ok++;
			$display("test %s: pass, %0d checks", cur_test, chk_cnt - test_chk0);
		end else begin
			$display("test %s: %0d errors in %0d checks", cur_test, err_cnt - test_err0,
				chk_cnt - test_chk0);
		end
	endtask

	// comparing process sampling at the falling edge
	initial begin : compare
		logic [71:0] e_slice;
		logic [71:0] a_slice;
		forever begin
			wait (done_cnt != req_cnt);
			if (cyc > chk_at) begin
				$display("%s: check meant for cycle %0d only started at cycle %0d",
					chk_name, chk_at, cyc);
				err_cnt++;
			end
			wait (cyc >= chk_at);
			@(negedge clk);
			chk_cnt++;
			for (int p = 0; p < `CONV3_COLS; p++) begin
				e_slice = exp_prod[72 * p +: 72];
				a_slice = o_products[72 * p +: 72];
				if (a_slice !== e_slice) begin
					$display("MISMATCH %s pos %0d expected %h actual %h", chk_name, p,
						e_slice, a_slice);
					err_cnt++;
				end
			end
			if (o_valid !== exp_valid) begin
				$display("MISMATCH %s o_valid expected %b actual %b", chk_name, exp_valid,
					o_valid);
				err_cnt++;
			end
			if (o_finish !== exp_finish) begin
				$display("MISMATCH %s o_finish expected %b actual %b", chk_name, exp_finish,
					o_finish);
				err_cnt++;
			end
			done_cnt++;
		end
	end

	initial begin : stimulus
		logic [63:0] d;
		int at;
		rst = 1'b0;
		i_ctrl = ctrl_nop; // code 0 would be END
		i_row_data = '0;
		i_row_valid = 1'b0;
		i_pad = 1'b0;
		i_stride = 1'b0;
		i_w_data = '0;
		i_w_valid = 1'b0;
		i_kernel_sel = '0;
		m_rows = '0;
		m_window = '0;
		m_phase = 1'b0;
		m_w = '0;
		m_wcnt = 0;
		m_sel = '0;
		m_stride = 1'b0;
		m_state = fsm_wait;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b1;

		begin_test("reset");
		check_settled("reset all zero");
		end_test();

		begin_test("stride1");
		for (int k = 0; k < `CONV3_W_WORDS; k++) begin
			rand64(d);
			send_weight(d);
		end
		for (int r = 0; r < 3; r++) begin
			rand64(d);
			send_row(d, 1'b0); // back to back rows
		end
		check_settled("stride1 kernel 0");
		end_test();

		begin_test("kernel_sel");
		for (int k = 0; k < `CONV3_KERNELS; k++) begin
			set_kernel(3'(k));
			check_settled($sformatf("kernel_sel k%0d", k));
		end
		end_test();

		begin_test("stride2");
		set_stride(1'b1);
		for (int r = 0; r < 4; r++) begin
			rand64(d);
			send_row(d, 1'b0);
			check_settled($sformatf("stride2 row %0d", r + 1)); // odd rows leave window alone
		end
		end_test();

		begin_test("padding");
		set_stride(1'b0);
		send_pad();
		check_settled("padding one pad");
		rand64(d);
		send_row(d, 1'b1);
		check_settled("padding row beats pad");
		send_pad();
		send_pad();
		check_settled("padding two pads"); // only row 0 holds data
		end_test();

		begin_test("control");
		set_kernel(3'd0);
		check_settled("control before start");
		command(ctrl_start, at);
		check_at("control valid two cycles after start", at + 3, 1'b0, 1'b0);
		check_at("control valid three cycles after start", at + 4, 1'b1, 1'b0);
		rand64(d);
		send_weight(d); // tenth word is dropped
		check_settled("control tenth word ignored");
		command(ctrl_hold, at);
		check_at("control valid two cycles after hold", at + 3, 1'b1, 1'b0);
		check_at("control valid three cycles after hold", at + 4, 1'b0, 1'b0);
		rand64(d);
		send_weight(d); // counter cleared so it lands at word 0
		check_settled("control reload word 0");
		command(ctrl_end, at);
		check_settled("control finish");
		command(ctrl_start, at);
		check_settled("control finish sticky");
		end_test();

		$display("tests %0d, passed %0d, checks %0d, errors %0d", tests_run, tests_ok,
			chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* conv3_engine.f */
+incdir+logic
+incdir+verification
logic/conv3_pkg.sv
logic/row_window.sv
logic/weight_buffer.sv
logic/tap_cube.sv
logic/conv_ctrl_fsm.sv
logic/conv3_engine.sv
verification/conv3_engine_tb.sv
